/* scan_chain_top.f */
scan_pkg.sv
slot_pkg.sv
clk_divider.sv
scan_slot.sv
scan_capture.sv
scan_sequencer.sv
scan_chain_top.sv
tb_scan_chain_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_scan_chain_top -f scan_chain_top.f

sim_out="$(./obj_dir/Vtb_scan_chain_top)"
echo "$sim_out"

if grep -qx "TESTS PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1

/* tb_scan_chain_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_scan_chain_top;

    localparam int DRIVE_DLY   = 5;                          // Input skew after posedge
    localparam int NUM_REFRESH = 64;                         // Upper bound on refreshes run
    localparam int REFRESH_MAX = 2 * 8 * 8 * 2 + 5 * 256 + 16;
    localparam int WATCHDOG_NS = (NUM_REFRESH * REFRESH_MAX + 1000) * 100;

    logic                       clk;
    logic                       rst_i;
    scan_pkg::drv_mode_e        mode_i;
    logic [scan_pkg::SEL_W-1:0] active_select_i;
    scan_pkg::io_word_t         inputs_i;
    logic                       set_clk_div_i;
    scan_pkg::io_word_t         outputs_o;
    logic                       ready_o;
    logic                       slow_clk_o;

    int                 errors;
    int                 n_checks;
    int                 pulse_cnt;
    int                 since_change;    // ready_o pulses since last stimulus change
    int                 cyc;
    int                 cyc_at_pulse;
    int                 iv_last;         // Cycles between the last two pulses
    int                 cur_sel;
    scan_pkg::io_word_t cur_word;
    logic               div_on;
    logic [2:0]         slow_hist;       // slow_clk_o at the last three pulses
    int                 seed_val;

    scan_chain_top uut (
        .clk             (clk),
        .rst_i           (rst_i),
        .mode_i          (mode_i),
        .active_select_i (active_select_i),
        .inputs_i        (inputs_i),
        .set_clk_div_i   (set_clk_div_i),
        .outputs_o       (outputs_o),
        .ready_o         (ready_o),
        .slow_clk_o      (slow_clk_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    function automatic scan_pkg::io_word_t slot_model(input int idx,
                                                      input scan_pkg::io_word_t word);
        scan_pkg::io_word_t res;
        case (slot_pkg::slot_op_for(idx))
            slot_pkg::OP_PASS:   res = word;
            slot_pkg::OP_INVERT: res = ~word;
            slot_pkg::OP_INCR:   res = word + 8'd1;
            default:             res = {word[3:0], word[7:4]};
        endcase
        return res;
    endfunction

    task automatic check_word(input string name, input scan_pkg::io_word_t exp,
                              input scan_pkg::io_word_t act);
        n_checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Fail t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Fail t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // ----------------------------------------------------------
    // Compare process, runs on every ready_o pulse
    // ----------------------------------------------------------
    always @(negedge clk)
    begin : compare_outputs
        scan_pkg::io_word_t fed;
        if (ready_o)
        begin
            pulse_cnt++;
            since_change++;
            iv_last      = cyc - cyc_at_pulse;
            cyc_at_pulse = cyc;
            slow_hist    = {slow_hist[1:0], slow_clk_o};
            if (pulse_cnt <= 2)
                check_word("outputs_o", 8'h00, outputs_o);    // No refresh done yet
            if (since_change >= 3)
            begin
                fed = cur_word;
                if (div_on)
                    fed[0] = slow_hist[2];    // Bit seen two refreshes back
                check_word("outputs_o", slot_model(cur_sel, fed), outputs_o);
                if (div_on)
                    check_bit("slow_clk_o", ~slow_hist[2], slow_clk_o);
            end
        end
    end

    task automatic wait_pulses(input int n);
        int target;
        target = pulse_cnt + n;
        while (pulse_cnt < target)
            @(posedge clk);
    endtask

    task automatic apply_stimulus(input int sel, input scan_pkg::io_word_t word);
        @(posedge clk);
        #DRIVE_DLY;
        active_select_i = scan_pkg::SEL_W'(sel);
        inputs_i        = word;
        cur_sel         = sel;
        cur_word        = word;
        since_change    = 0;
    endtask

    // Hand-driven chain in external mode
    task automatic external_chain_test;
        logic [63:0] chain_model;
        logic        d;
        chain_model = '0;
        for (int k = 0; k < 80; k++)
        begin
            @(posedge clk);
            #DRIVE_DLY;
            d        = logic'($urandom % 2);
            inputs_i = {6'b0, d, 1'b1};    // data, strobe
            @(negedge clk);
            check_bit("outputs_o[0]", 1'b0, outputs_o[0]);
            check_bit("ready_o", 1'b0, ready_o);
            @(posedge clk);
            #DRIVE_DLY;
            inputs_i    = '0;
            chain_model = {chain_model[62:0], d};
            @(negedge clk);
            if (k >= 63)    // Tail holds a driven bit from here on
                check_word("outputs_o", {6'b0, chain_model[63], 1'b1}, outputs_o);
            else
                check_bit("outputs_o[0]", 1'b1, outputs_o[0]);
            check_bit("ready_o", 1'b0, ready_o);
        end
    endtask

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    initial
    begin : stimulus
        int long_iv;
        int short_iv;
        seed_val        = $urandom(32'had2e);
        clk             = 1'b0;
        rst_i           = 1'b1;
        mode_i          = scan_pkg::DRV_INTERNAL;
        active_select_i = '0;
        inputs_i        = '0;
        set_clk_div_i   = 1'b0;
        errors          = 0;
        n_checks        = 0;
        pulse_cnt       = 0;
        since_change    = 0;
        cyc             = 0;
        cyc_at_pulse    = 0;
        iv_last         = 0;
        cur_sel         = 0;
        cur_word        = '0;
        div_on          = 1'b0;
        slow_hist       = '0;

        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_i = 1'b0;
        @(negedge clk);
        check_bit("ready_o", 1'b0, ready_o);
        check_word("outputs_o", 8'h00, outputs_o);
        wait_pulses(3);

        // Every slot with a random word
        for (int s = 0; s < scan_pkg::NUM_DESIGNS; s++)
        begin
            apply_stimulus(s, scan_pkg::io_word_t'($urandom));
            wait_pulses(4);
        end

        // Switch slot only, word held
        apply_stimulus(5, cur_word);
        wait_pulses(5);
        apply_stimulus(2, cur_word);
        wait_pulses(5);
        long_iv = iv_last;

        // Wait-state config of 2
        apply_stimulus(6, 8'h02);
        mode_i = scan_pkg::DRV_INTERNAL_CFG;
        repeat (6) @(posedge clk);
        #DRIVE_DLY;
        mode_i = scan_pkg::DRV_INTERNAL;
        wait_pulses(4);
        short_iv = iv_last;
        $display("Refresh interval %0d cycles by default, %0d after config", long_iv, short_iv);
        check_bit("ready_o interval shorter", 1'b1, short_iv < long_iv);

        // Divider with compare 1 on the PASS slot
        apply_stimulus(0, 8'h01);
        set_clk_div_i = 1'b1;
        div_on        = 1'b1;
        repeat (8) @(posedge clk);
        apply_stimulus(0, scan_pkg::io_word_t'($urandom));
        set_clk_div_i = 1'b0;
        wait_pulses(8);

        // External mode
        @(posedge clk);
        #DRIVE_DLY;
        mode_i   = scan_pkg::DRV_EXTERNAL;
        inputs_i = '0;
        external_chain_test();

        $display("Checks run %0d, errors %0d", n_checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("Run timed out before all refreshes completed");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* scan_chain_top.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_chain_top (
    input  wire                       clk,
    input  wire                       rst_i,
    input  wire scan_pkg::drv_mode_e  mode_i,
    input  wire [scan_pkg::SEL_W-1:0] active_select_i,
    input  wire scan_pkg::io_word_t   inputs_i,
    input  wire                       set_clk_div_i,
    output wire scan_pkg::io_word_t   outputs_o,
    output wire                       ready_o,
    output wire                       slow_clk_o
);

    scan_pkg::scan_ctrl_t              chain_ctrl;
    logic                              return_strobe;
    logic                              capture;
    logic [scan_pkg::NUM_DESIGNS:0]    chain_data;    // Slot i in, slot i+1 in

    scan_sequencer u_sequencer (
        .clk             (clk),
        .rst_i           (rst_i),
        .mode_i          (mode_i),
        .active_select_i (active_select_i),
        .inputs_i        (inputs_i),
        .set_clk_div_i   (set_clk_div_i),
        .ready_o         (ready_o),
        .slow_clk_o      (slow_clk_o),
        .chain_ctrl_o    (chain_ctrl),
        .return_strobe_o (return_strobe),
        .capture_o       (capture)
    );

    assign chain_data[0] = chain_ctrl.data;

    // ----------------------------------------------------------
    // Slots on the chain
    // ----------------------------------------------------------
    for (genvar i = 0; i < scan_pkg::NUM_DESIGNS; i++)
    begin : g_slot
        scan_slot #(
            .SLOT_IDX (i)
        ) u_slot (
            .clk    (clk),
            .rst_i  (rst_i),
            .ctrl_i (chain_ctrl),
            .data_i (chain_data[i]),
            .data_o (chain_data[i+1])
        );
    end

    scan_capture u_capture (
        .clk             (clk),
        .rst_i           (rst_i),
        .mode_i          (mode_i),
        .tail_i          (chain_data[scan_pkg::NUM_DESIGNS]),
        .return_strobe_i (return_strobe),
        .capture_i       (capture),
        .outputs_o       (outputs_o)
    );

endmodule

`default_nettype wire

/* scan_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_sequencer (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire scan_pkg::drv_mode_e mode_i,
    input  wire [scan_pkg::SEL_W-1:0] active_select_i,
    input  wire scan_pkg::io_word_t  inputs_i,
    input  wire                      set_clk_div_i,
    output logic                     ready_o,
    output logic                     slow_clk_o,
    output scan_pkg::scan_ctrl_t     chain_ctrl_o,
    output logic                     return_strobe_o,
    output logic                     capture_o
);

    logic [2:0]                     rst_shift;
    logic                           rst_int;
    logic                           active;
    scan_pkg::seq_state_e           state;
    scan_pkg::seq_state_e           state_nxt;
    logic [scan_pkg::BIT_CNT_W-1:0] bit_cnt;
    logic                           bit_last;
    logic                           bit_penult;
    logic [scan_pkg::SEL_W-1:0]     proj_cnt;
    logic                           proj_sel;
    logic                           proj_done;
    logic                           shift_hi;
    logic                           in_load;
    scan_pkg::io_word_t             in_sync;
    scan_pkg::io_word_t             in_reg;
    scan_pkg::io_word_t             in_shift;
    logic [scan_pkg::WS_W-1:0]      ws_cnt;
    logic [scan_pkg::WS_W-1:0]      ws_cfg;
    logic                           ws_run;
    logic                           ws_done;
    logic [2:0]                     ws_set_sync;
    logic                           ws_set_now;
    logic                           div_active;
    scan_pkg::scan_ctrl_t           int_ctrl;
    scan_pkg::scan_ctrl_t           ext_ctrl;

    // Local reset, released on clk
    always_ff @(posedge clk or posedge rst_i)
    begin
        if (rst_i)
            rst_shift <= 3'b111;
        else
            rst_shift <= {rst_shift[1:0], 1'b0};
    end

    assign rst_int = rst_shift[2];

    // ----------------------------------------------------------
    // Chain control mux
    // ----------------------------------------------------------
    assign ext_ctrl = '{strobe: inputs_i[0], data: inputs_i[1],
                        sel: inputs_i[2], latch: inputs_i[3]};

    assign chain_ctrl_o = mode_i[1] ? int_ctrl : ext_ctrl;

    always_ff @(posedge clk or posedge rst_int)
    begin
        if (rst_int)
            return_strobe_o <= 1'b0;
        else
            return_strobe_o <= chain_ctrl_o.strobe;    // Strobe back from chain end
    end

    // Two-flop input sync
    always_ff @(posedge clk)
    begin
        in_sync <= inputs_i;
        in_reg  <= mode_i[1] ? in_sync : '0;
    end

    // ----------------------------------------------------------
    // Refresh FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge rst_int)
    begin
        if (rst_int)
        begin
            active <= 1'b0;
            state  <= scan_pkg::IDLE;
        end
        else
        begin
            active <= mode_i[1];
            state  <= state_nxt;
        end
    end

    assign ready_o = active && (state == scan_pkg::IDLE);

    always_comb
    begin
        state_nxt = state;
        case (state)
            scan_pkg::IDLE:          if (active) state_nxt = scan_pkg::IN_LOAD;
            scan_pkg::IN_LOAD:       state_nxt = scan_pkg::IN_SHIFT_LO;
            scan_pkg::IN_SHIFT_LO:   state_nxt = scan_pkg::IN_SHIFT_HI;
            scan_pkg::IN_SHIFT_HI:
                state_nxt = (proj_sel && bit_last) ? scan_pkg::IN_LATCH_WAIT
                                                   : scan_pkg::IN_SHIFT_LO;
            scan_pkg::IN_LATCH_WAIT: if (ws_done) state_nxt = scan_pkg::IN_LATCH;
            scan_pkg::IN_LATCH:      state_nxt = scan_pkg::OUT_LOAD_PRE;
            scan_pkg::OUT_LOAD_PRE:  if (ws_done) state_nxt = scan_pkg::OUT_LOAD;
            scan_pkg::OUT_LOAD:      state_nxt = scan_pkg::OUT_LOAD_POST;
            scan_pkg::OUT_LOAD_POST: if (ws_done) state_nxt = scan_pkg::OUT_LOAD_CLR;
            scan_pkg::OUT_LOAD_CLR:  if (ws_done) state_nxt = scan_pkg::OUT_SHIFT_LO;
            scan_pkg::OUT_SHIFT_LO:  state_nxt = scan_pkg::OUT_SHIFT_HI;
            scan_pkg::OUT_SHIFT_HI:
                state_nxt = (proj_done && bit_penult) ? scan_pkg::OUT_CAP_WAIT
                                                      : scan_pkg::OUT_SHIFT_LO;
            scan_pkg::OUT_CAP_WAIT:  if (ws_done) state_nxt = scan_pkg::OUT_CAP;
            scan_pkg::OUT_CAP:       state_nxt = scan_pkg::IDLE;
            default:                 state_nxt = scan_pkg::IDLE;
        endcase
    end

    assign shift_hi = (state == scan_pkg::IN_SHIFT_HI) || (state == scan_pkg::OUT_SHIFT_HI);
    assign in_load  = (state == scan_pkg::IN_LOAD);

    // Bit and project counters
    // proj_cnt carries over, so the out phase runs up to NUM_DESIGNS
    always_ff @(posedge clk or posedge rst_int)
    begin
        if (rst_int)
        begin
            bit_cnt  <= '0;
            proj_cnt <= '0;
        end
        else if (state == scan_pkg::IDLE)
        begin
            bit_cnt  <= '0;
            proj_cnt <= '0;
        end
        else if (shift_hi)
        begin
            bit_cnt <= bit_last ? '0 : bit_cnt + 1'b1;
            if (bit_last)
                proj_cnt <= proj_cnt + 1'b1;
        end
    end

    assign bit_last   = (bit_cnt == scan_pkg::BIT_CNT_W'(scan_pkg::NUM_IOS - 1));
    // Load strobe already returned the MSB, so the out phase stops one bit short
    assign bit_penult = (bit_cnt == scan_pkg::BIT_CNT_W'(scan_pkg::NUM_IOS - 2));
    assign proj_sel   = (proj_cnt == active_select_i);
    assign proj_done  = (proj_cnt == scan_pkg::SEL_W'(scan_pkg::NUM_DESIGNS));

    // Registered chain control
    always_ff @(posedge clk or posedge rst_int)
    begin
        if (rst_int)
        begin
            int_ctrl  <= '0;
            capture_o <= 1'b0;
        end
        else
        begin
            int_ctrl.strobe <= shift_hi || (state == scan_pkg::OUT_LOAD);
            int_ctrl.data   <= in_shift[scan_pkg::NUM_IOS-1];
            int_ctrl.sel    <= (state == scan_pkg::OUT_LOAD_PRE) ||
                               (state == scan_pkg::OUT_LOAD) ||
                               (state == scan_pkg::OUT_LOAD_POST);
            int_ctrl.latch  <= (state == scan_pkg::IN_LATCH);
            capture_o       <= (state == scan_pkg::OUT_CAP);
        end
    end

    // Input word, MSB first then zeros
    always_ff @(posedge clk)
    begin
        if (in_load)
            in_shift <= div_active ? {in_reg[scan_pkg::NUM_IOS-1:1], slow_clk_o} : in_reg;
        else if (state == scan_pkg::IN_SHIFT_HI)
            in_shift <= {in_shift[scan_pkg::NUM_IOS-2:0], 1'b0};
    end

    // ----------------------------------------------------------
    // Wait states
    // ----------------------------------------------------------
    assign ws_run = (state == scan_pkg::IN_LATCH_WAIT) || (state == scan_pkg::OUT_LOAD_PRE) ||
                    (state == scan_pkg::OUT_LOAD_POST) || (state == scan_pkg::OUT_LOAD_CLR) ||
                    (state == scan_pkg::OUT_CAP_WAIT);
    assign ws_done = (ws_cnt == ws_cfg);

    always_ff @(posedge clk or posedge rst_int)
    begin
        if (rst_int)
            ws_cnt <= '0;
        else if (!ws_run || ws_done)
            ws_cnt <= '0;
        else
            ws_cnt <= ws_cnt + 1'b1;
    end

    // Config load on entry to the CFG mode
    always_ff @(posedge clk or posedge rst_int)
    begin
        if (rst_int)
        begin
            ws_set_sync <= '0;
            ws_set_now  <= 1'b0;
            ws_cfg      <= scan_pkg::WS_W'(scan_pkg::WS_DEFAULT);
        end
        else
        begin
            ws_set_sync <= {ws_set_sync[1:0], mode_i == scan_pkg::DRV_INTERNAL_CFG};
            ws_set_now  <= ws_set_sync[1] & ~ws_set_sync[2];
            if (ws_set_now)
                ws_cfg <= inputs_i;
        end
    end

    clk_divider u_clk_divider (
        .clk           (clk),
        .rst_i         (rst_int),
        .load_strobe_i (in_load),
        .set_i         (set_clk_div_i),
        .divider_i     (inputs_i),
        .active_o      (div_active),
        .slow_clk_o    (slow_clk_o)
    );

    // Strobe and latch on the chain are exclusive, pins included
    a_strobe_latch: assert property (@(posedge clk) disable iff (rst_int)
        !(chain_ctrl_o.strobe && chain_ctrl_o.latch));

    // External mode holds the FSM in IDLE
    a_ext_idle: assert property (@(posedge clk) disable iff (rst_int)
        (state == scan_pkg::IDLE && mode_i == scan_pkg::DRV_EXTERNAL &&
         $past(mode_i) == scan_pkg::DRV_EXTERNAL) |=> (state == scan_pkg::IDLE));

endmodule

`default_nettype wire

/* scan_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_capture (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire scan_pkg::drv_mode_e mode_i,
    input  wire                      tail_i,
    input  wire                      return_strobe_i,
    input  wire                      capture_i,
    output scan_pkg::io_word_t       outputs_o
);

    scan_pkg::io_word_t shift_q;
    scan_pkg::io_word_t out_q;

    // Return shift register
    always_ff @(posedge clk)
    begin
        if (return_strobe_i)
            shift_q <= {shift_q[scan_pkg::NUM_IOS-2:0], tail_i};
    end

    // Output register, updated once per refresh
    always_ff @(posedge clk or posedge rst_i)
    begin
        if (rst_i)
            out_q <= '0;
        else if (capture_i)
            out_q <= shift_q;
    end

    // External mode shows the raw chain return
    assign outputs_o = mode_i[1] ? out_q
                                 : {{(scan_pkg::NUM_IOS - 2){1'b0}}, tail_i, return_strobe_i};

endmodule

`default_nettype wire

/* scan_slot.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_slot #(
    parameter int SLOT_IDX = 0
) (
    input  wire                        clk,
    input  wire                        rst_i,
    input  wire scan_pkg::scan_ctrl_t  ctrl_i,
    input  wire                        data_i,
    output logic                       data_o
);

    localparam slot_pkg::slot_op_e OP = slot_pkg::slot_op_for(SLOT_IDX);
    localparam int                 H  = scan_pkg::IO_HALF;

    scan_pkg::io_word_t scan_q;        // Scan flops
    scan_pkg::io_word_t latch_q;       // Design input
    scan_pkg::io_word_t design_out;

    // ----------------------------------------------------------
    // Tiny design
    // ----------------------------------------------------------
    always_comb
    begin
        case (OP)
            slot_pkg::OP_PASS:   design_out = latch_q;
            slot_pkg::OP_INVERT: design_out = ~latch_q;
            slot_pkg::OP_INCR:   design_out = latch_q + 1'b1;    // Wraps at 256
            default:
                design_out = {latch_q[H-1:0], latch_q[scan_pkg::NUM_IOS-1:H]};
        endcase
    end

    // Shift or load on strobe
    always_ff @(posedge clk or posedge rst_i)
    begin
        if (rst_i)
            scan_q <= '0;
        else if (ctrl_i.strobe)
        begin
            if (ctrl_i.sel)
                scan_q <= design_out;
            else
                scan_q <= {scan_q[scan_pkg::NUM_IOS-2:0], data_i};
        end
    end

    always_ff @(posedge clk or posedge rst_i)
    begin
        if (rst_i)
            latch_q <= '0;
        else if (ctrl_i.latch)
            latch_q <= scan_q;
    end

    assign data_o = scan_q[scan_pkg::NUM_IOS-1];    // Toward next slot

    // Latch must not see a load in progress
    a_latch_sel: assert property (@(posedge clk) disable iff (rst_i)
        !(ctrl_i.latch && ctrl_i.sel));

endmodule

`default_nettype wire

/* clk_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_divider (
    input  wire                clk,
    input  wire                rst_i,
    input  wire                load_strobe_i,
    input  wire                set_i,
    input  wire scan_pkg::io_word_t divider_i,
    output logic               active_o,
    output logic               slow_clk_o
);

    logic [2:0]         set_sync;
    logic               set_now;
    scan_pkg::io_word_t compare_q;
    scan_pkg::io_word_t count_q;
    logic               match;

    // Set edge detect behind three flops
    always_ff @(posedge clk or posedge rst_i)
    begin
        if (rst_i)
        begin
            set_sync <= '0;
            set_now  <= 1'b0;
            active_o <= 1'b0;
        end
        else
        begin
            set_sync <= {set_sync[1:0], set_i};
            set_now  <= set_sync[1] & ~set_sync[2];
            if (set_now)
                active_o <= 1'b1;    // Sticky until reset
        end
    end

    always_ff @(posedge clk)
    begin
        if (set_now)
            compare_q <= divider_i;
    end

    assign match = (count_q == compare_q);

    // One count per refresh load
    always_ff @(posedge clk or posedge rst_i)
    begin
        if (rst_i)
        begin
            count_q    <= '0;
            slow_clk_o <= 1'b0;
        end
        else if (set_now)
            count_q <= '0;
        else if (load_strobe_i && active_o)
        begin
            count_q    <= match ? '0 : count_q + 1'b1;
            slow_clk_o <= slow_clk_o ^ match;
        end
    end

endmodule

`default_nettype wire

/* slot_pkg.sv */
`default_nettype none

package slot_pkg;

    // Functions a slot can host
    typedef enum logic [1:0] {
        OP_PASS,
        OP_INVERT,
        OP_INCR,           // Add one, wraps
        OP_NIBBLE_SWAP
    } slot_op_e;

    // Slot index to function, repeats every four slots
    function automatic slot_op_e slot_op_for(input int idx);
        return slot_op_e'(idx % 4);
    endfunction

endpackage

`default_nettype wire

/* scan_pkg.sv */
`default_nettype none

package scan_pkg;

    // ----------------------------------------------------------
    // Chain geometry
    // ----------------------------------------------------------
    localparam int NUM_DESIGNS = 8;              // Slots on the chain
    localparam int NUM_IOS     = 8;              // Bits per slot and pin width
    localparam int IO_HALF     = NUM_IOS / 2;
    localparam int BIT_CNT_W   = $clog2(NUM_IOS);
    localparam int SEL_W       = 9;              // Design select width
    localparam int WS_W        = 8;
    localparam int WS_DEFAULT  = 10;             // Wait states after reset

    typedef logic [NUM_IOS-1:0] io_word_t;

    // Refresh sequence
    typedef enum logic [3:0] {
        IDLE,
        IN_LOAD,           // Capture input word
        IN_SHIFT_LO,
        IN_SHIFT_HI,       // Strobe issued from here
        IN_LATCH_WAIT,
        IN_LATCH,
        OUT_LOAD_PRE,      // Select raised
        OUT_LOAD,          // Single load strobe
        OUT_LOAD_POST,
        OUT_LOAD_CLR,      // Back to shift mode
        OUT_SHIFT_LO,
        OUT_SHIFT_HI,
        OUT_CAP_WAIT,
        OUT_CAP
    } seq_state_e;

    // Who drives the chain
    typedef enum logic [1:0] {
        DRV_EXTERNAL     = 2'b00,
        DRV_INTERNAL     = 2'b10,
        DRV_INTERNAL_CFG = 2'b11    // Internal, also loads wait states
    } drv_mode_e;

    typedef struct packed {
        logic strobe;    // One-cycle shift strobe
        logic data;      // Head data bit
        logic sel;       // Load design outputs instead of shifting
        logic latch;     // Copy scan flops into input latch
    } scan_ctrl_t;

endpackage

`default_nettype wire
